// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := issue_tb
FILELIST  := verilog.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// File: design/fust_slot.sv
/* FUST row */

`timescale 1ns/1ps
`default_nettype none

module fust_slot
    import isa_pkg::*;
    import issue_pkg::*;
#(
    parameter int  AGE_WIDTH = issue_pkg::AGE_WIDTH,
    parameter fu_e FU_INDEX  = FU_ALU
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 freeze,
    input  logic                 disp_en,
    input  logic                 any_disp,
    input  aluop_e               disp_op,
    input  regbits_t             disp_rs1,
    input  regbits_t             disp_rs2,
    input  regbits_t             disp_rd,
    input  word_t                disp_imm,
    input  logic                 disp_i_type,
    input  logic                 disp_lui,
    input  tag_t                 disp_t1,
    input  tag_t                 disp_t2,
    input  logic [NUM_FU-1:0]    fu_done,
    input  logic                 grant,
    output logic                 ready,
    output logic [AGE_WIDTH-1:0] age,
    output logic                 busy,
    output aluop_e               row_op,
    output regbits_t             row_rs1,
    output regbits_t             row_rs2,
    output regbits_t             row_rd,
    output word_t                row_imm,
    output logic                 row_i_type,
    output logic                 row_lui
);

    fust_state_e       state;
    tag_t              t1_q;
    tag_t              t2_q;
    tag_t              t1_n;
    tag_t              t2_n;
    logic [NUM_FU-1:0] done_eff;
    logic              accept;
    logic              i_type_q;

    // a tag naming a unit that completes this cycle is satisfied
    function automatic tag_t clear_tag(tag_t t, logic [NUM_FU-1:0] done);
        if (t != '0 && done[t - 2'd1]) begin
            return '0;
        end
        return t;
    endfunction

    // completions are not seen while the stage is frozen
    assign done_eff = freeze ? '0 : fu_done;
    assign t1_n     = clear_tag(t1_q, done_eff);
    assign t2_n     = clear_tag(t2_q, done_eff);

    assign ready = (state == FUST_WAIT || state == FUST_RDY) && t1_n == '0 && t2_n == '0;
    assign busy  = state != FUST_EMPTY;

    // own completion frees the row in time to take a new dispatch
    assign accept = !freeze && disp_en &&
                    (state == FUST_EMPTY || (state == FUST_EX && done_eff[FU_INDEX]));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= FUST_EMPTY;
            age   <= '0;
            t1_q  <= '0;
            t2_q  <= '0;
        end else if (!freeze) begin
            t1_q <= t1_n;
            t2_q <= t2_n;
            if (accept) begin
                state <= FUST_WAIT;
                age   <= AGE_WIDTH'(1);
                t1_q  <= clear_tag(disp_t1, done_eff);
                t2_q  <= clear_tag(disp_t2, done_eff);
            end else begin
                case (state)
                    FUST_WAIT, FUST_RDY: begin
                        if (grant) begin
                            state <= FUST_EX;
                            age   <= '0;
                        end else begin
                            if (ready)
                                state <= FUST_RDY;
                            // newer instruction arrived elsewhere, saturate
                            if (any_disp && age != '1)
                                age <= age + 1'b1;
                        end
                    end
                    FUST_EX: begin
                        if (done_eff[FU_INDEX])
                            state <= FUST_EMPTY;
                    end
                    default: begin
                        state <= state;
                    end
                endcase
            end
        end
    end

    // row payload
    always_ff @(posedge CLK) begin
        if (accept) begin
            row_op   <= disp_op;
            row_rs1  <= disp_rs1;
            row_rs2  <= disp_rs2;
            row_rd   <= disp_rd;
            row_imm  <= disp_imm;
            i_type_q <= disp_i_type;
            row_lui  <= disp_lui;
        end
    end

    // immediate only replaces operand 2 for the alu
    assign row_i_type = i_type_q && (FU_INDEX == FU_ALU);

endmodule

`default_nettype wire

// File: design/isa_pkg.sv
/* scalar ISA types */

`default_nettype none

package isa_pkg;

    // datapath and register file sizing
    parameter int DATA_WIDTH = 32;
    parameter int REG_COUNT  = 32;

    typedef logic [DATA_WIDTH-1:0]        word_t;
    typedef logic [$clog2(REG_COUNT)-1:0] regbits_t;

    // alu operations carried in a row and in the issue packet
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SLT = 4'd7
    } aluop_e;

endpackage

`default_nettype wire

// File: design/issue_latch.sv
/* issue packet latch */

`timescale 1ns/1ps
`default_nettype none

module issue_latch
    import isa_pkg::*;
    import issue_pkg::*;
#(
    parameter int DATA_WIDTH = isa_pkg::DATA_WIDTH
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  freeze,
    input  logic [NUM_FU-1:0]     grant,
    input  logic [NUM_FU-1:0]     fu_done,
    input  aluop_e                alu_op,
    input  regbits_t              alu_rs1,
    input  regbits_t              alu_rs2,
    input  regbits_t              alu_rd,
    input  word_t                 alu_imm,
    input  logic                  alu_i_type,
    input  logic                  alu_lui,
    input  aluop_e                ldst_op,
    input  regbits_t              ldst_rs1,
    input  regbits_t              ldst_rs2,
    input  regbits_t              ldst_rd,
    input  word_t                 ldst_imm,
    input  logic                  ldst_i_type,
    input  logic                  ldst_lui,
    input  aluop_e                br_op,
    input  regbits_t              br_rs1,
    input  regbits_t              br_rs2,
    input  regbits_t              br_rd,
    input  word_t                 br_imm,
    input  logic                  br_i_type,
    input  logic                  br_lui,
    input  logic [DATA_WIDTH-1:0] rdat1,
    input  logic [DATA_WIDTH-1:0] rdat2,
    output regbits_t              rsel1,
    output regbits_t              rsel2,
    output logic [NUM_FU-1:0]     fu_en,
    output aluop_e                iss_op,
    output regbits_t              iss_rd,
    output word_t                 iss_imm,
    output logic [DATA_WIDTH-1:0] iss_rdat1,
    output logic [DATA_WIDTH-1:0] iss_rdat2
);

    aluop_e                sel_op;
    regbits_t              sel_rd;
    word_t                 sel_imm;
    logic                  sel_i_type;
    logic                  sel_lui;
    logic [DATA_WIDTH-1:0] op1;
    logic [DATA_WIDTH-1:0] op2;

    // grant is one-hot or zero
    always_comb begin
        sel_op     = ALU_ADD;
        rsel1      = '0;
        rsel2      = '0;
        sel_rd     = '0;
        sel_imm    = '0;
        sel_i_type = 1'b0;
        sel_lui    = 1'b0;
        if (grant[FU_ALU]) begin
            sel_op     = alu_op;
            rsel1      = alu_rs1;
            rsel2      = alu_rs2;
            sel_rd     = alu_rd;
            sel_imm    = alu_imm;
            sel_i_type = alu_i_type;
            sel_lui    = alu_lui;
        end else if (grant[FU_LDST]) begin
            sel_op     = ldst_op;
            rsel1      = ldst_rs1;
            rsel2      = ldst_rs2;
            sel_rd     = ldst_rd;
            sel_imm    = ldst_imm;
            sel_i_type = ldst_i_type;
            sel_lui    = ldst_lui;
        end else if (grant[FU_BRANCH]) begin
            sel_op     = br_op;
            rsel1      = br_rs1;
            rsel2      = br_rs2;
            sel_rd     = br_rd;
            sel_imm    = br_imm;
            sel_i_type = br_i_type;
            sel_lui    = br_lui;
        end
    end

    // lui adds the immediate to zero
    assign op1 = sel_lui ? '0 : rdat1;
    // only the alu row can present a live i-type flag
    assign op2 = sel_i_type ? DATA_WIDTH'(sel_imm) : rdat2;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            fu_en <= '0;
        else if (!freeze)
            fu_en <= grant | (fu_en & ~fu_done);
    end

    // packet holds until the next grant
    always_ff @(posedge CLK) begin
        if (!freeze && |grant) begin
            iss_op    <= sel_op;
            iss_rd    <= sel_rd;
            iss_imm   <= sel_imm;
            iss_rdat1 <= op1;
            iss_rdat2 <= op2;
        end
    end

endmodule

`default_nettype wire

// File: design/issue_pkg.sv
/* issue stage types */

`default_nettype none

package issue_pkg;

    // one table row per functional unit
    parameter int NUM_FU    = 3;
    parameter int AGE_WIDTH = 2;

    // row life cycle
    typedef enum logic [1:0] {
        FUST_EMPTY = 2'd0,
        FUST_WAIT  = 2'd1,
        FUST_RDY   = 2'd2,
        FUST_EX    = 2'd3
    } fust_state_e;

    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_LDST   = 2'd1,
        FU_BRANCH = 2'd2
    } fu_e;

    // zero when the operand is available, else producing unit index plus one
    typedef logic [1:0] tag_t;

endpackage

`default_nettype wire

// File: design/issue_select.sv
/* oldest ready select */

`timescale 1ns/1ps
`default_nettype none

module issue_select
    import issue_pkg::*;
#(
    parameter int AGE_WIDTH = issue_pkg::AGE_WIDTH
) (
    input  logic [NUM_FU-1:0]    ready,
    input  logic [AGE_WIDTH-1:0] age_alu,
    input  logic [AGE_WIDTH-1:0] age_ldst,
    input  logic [AGE_WIDTH-1:0] age_br,
    input  logic                 freeze,
    output logic [NUM_FU-1:0]    grant
);

    logic [AGE_WIDTH-1:0] ages [NUM_FU];

    assign ages[FU_ALU]    = age_alu;
    assign ages[FU_LDST]   = age_ldst;
    assign ages[FU_BRANCH] = age_br;

    // strict compare so equal ages go to the lower unit index
    always_comb begin
        logic                 found;
        logic [AGE_WIDTH-1:0] best_age;
        int unsigned          best;
        grant    = '0;
        found    = 1'b0;
        best_age = '0;
        best     = 0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (ready[i] && (!found || ages[i] > best_age)) begin
                found    = 1'b1;
                best_age = ages[i];
                best     = i;
            end
        end
        // single read port, at most one grant
        if (found && !freeze)
            grant[best] = 1'b1;
    end

endmodule

`default_nettype wire

// File: design/issue_top.sv
/* issue stage top */

`timescale 1ns/1ps
`default_nettype none

module issue_top
    import isa_pkg::*;
    import issue_pkg::*;
#(
    parameter int DATA_WIDTH = isa_pkg::DATA_WIDTH,
    parameter int AGE_WIDTH  = issue_pkg::AGE_WIDTH
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  disp_en,
    input  fu_e                   disp_fu,
    input  aluop_e                disp_op,
    input  regbits_t              disp_rs1,
    input  regbits_t              disp_rs2,
    input  regbits_t              disp_rd,
    input  word_t                 disp_imm,
    input  logic                  disp_i_type,
    input  logic                  disp_lui,
    input  tag_t                  disp_t1,
    input  tag_t                  disp_t2,
    input  logic                  freeze,
    input  logic [NUM_FU-1:0]     fu_done,
    input  logic                  wb_en,
    input  regbits_t              wb_sel,
    input  logic [DATA_WIDTH-1:0] wb_data,
    output logic [NUM_FU-1:0]     busy,
    output logic [NUM_FU-1:0]     fu_en,
    output aluop_e                iss_op,
    output regbits_t              iss_rd,
    output word_t                 iss_imm,
    output logic [DATA_WIDTH-1:0] iss_rdat1,
    output logic [DATA_WIDTH-1:0] iss_rdat2
);

    logic [NUM_FU-1:0]     slot_disp;
    logic [NUM_FU-1:0]     slot_ready;
    logic [NUM_FU-1:0]     grant;
    logic                  any_disp;
    logic [AGE_WIDTH-1:0]  age_alu, age_ldst, age_br;
    aluop_e                alu_op, ldst_op, br_op;
    regbits_t              alu_rs1, ldst_rs1, br_rs1;
    regbits_t              alu_rs2, ldst_rs2, br_rs2;
    regbits_t              alu_rd, ldst_rd, br_rd;
    word_t                 alu_imm, ldst_imm, br_imm;
    logic                  alu_i_type, ldst_i_type, br_i_type;
    logic                  alu_lui, ldst_lui, br_lui;
    regbits_t              rsel1, rsel2;
    logic [DATA_WIDTH-1:0] rdat1, rdat2;

    // dispatch decoded to the target row
    assign slot_disp[FU_ALU]    = disp_en && (disp_fu == FU_ALU);
    assign slot_disp[FU_LDST]   = disp_en && (disp_fu == FU_LDST);
    assign slot_disp[FU_BRANCH] = disp_en && (disp_fu == FU_BRANCH);

    // a row takes dispatch when empty or completing, this ages the others
    assign any_disp = !freeze && |(slot_disp & (~busy | fu_done));

    fust_slot #(.AGE_WIDTH(AGE_WIDTH), .FU_INDEX(FU_ALU)) u_slot_alu (
        .CLK, .nRST, .freeze, .disp_en(slot_disp[FU_ALU]), .any_disp,
        .disp_op, .disp_rs1, .disp_rs2, .disp_rd, .disp_imm, .disp_i_type, .disp_lui,
        .disp_t1, .disp_t2, .fu_done, .grant(grant[FU_ALU]),
        .ready(slot_ready[FU_ALU]), .age(age_alu), .busy(busy[FU_ALU]),
        .row_op(alu_op), .row_rs1(alu_rs1), .row_rs2(alu_rs2), .row_rd(alu_rd),
        .row_imm(alu_imm), .row_i_type(alu_i_type), .row_lui(alu_lui)
    );

    fust_slot #(.AGE_WIDTH(AGE_WIDTH), .FU_INDEX(FU_LDST)) u_slot_ldst (
        .CLK, .nRST, .freeze, .disp_en(slot_disp[FU_LDST]), .any_disp,
        .disp_op, .disp_rs1, .disp_rs2, .disp_rd, .disp_imm, .disp_i_type, .disp_lui,
        .disp_t1, .disp_t2, .fu_done, .grant(grant[FU_LDST]),
        .ready(slot_ready[FU_LDST]), .age(age_ldst), .busy(busy[FU_LDST]),
        .row_op(ldst_op), .row_rs1(ldst_rs1), .row_rs2(ldst_rs2), .row_rd(ldst_rd),
        .row_imm(ldst_imm), .row_i_type(ldst_i_type), .row_lui(ldst_lui)
    );

    fust_slot #(.AGE_WIDTH(AGE_WIDTH), .FU_INDEX(FU_BRANCH)) u_slot_br (
        .CLK, .nRST, .freeze, .disp_en(slot_disp[FU_BRANCH]), .any_disp,
        .disp_op, .disp_rs1, .disp_rs2, .disp_rd, .disp_imm, .disp_i_type, .disp_lui,
        .disp_t1, .disp_t2, .fu_done, .grant(grant[FU_BRANCH]),
        .ready(slot_ready[FU_BRANCH]), .age(age_br), .busy(busy[FU_BRANCH]),
        .row_op(br_op), .row_rs1(br_rs1), .row_rs2(br_rs2), .row_rd(br_rd),
        .row_imm(br_imm), .row_i_type(br_i_type), .row_lui(br_lui)
    );

    issue_select #(.AGE_WIDTH(AGE_WIDTH)) u_select (
        .ready(slot_ready), .age_alu, .age_ldst, .age_br, .freeze, .grant
    );

    regfile #(.DATA_WIDTH(DATA_WIDTH)) u_regfile (
        .CLK, .nRST, .wen(wb_en), .wsel(wb_sel), .wdata(wb_data),
        .rsel1, .rsel2, .rdat1, .rdat2
    );

    issue_latch #(.DATA_WIDTH(DATA_WIDTH)) u_latch (
        .CLK, .nRST, .freeze, .grant, .fu_done,
        .alu_op, .alu_rs1, .alu_rs2, .alu_rd, .alu_imm, .alu_i_type, .alu_lui,
        .ldst_op, .ldst_rs1, .ldst_rs2, .ldst_rd, .ldst_imm, .ldst_i_type, .ldst_lui,
        .br_op, .br_rs1, .br_rs2, .br_rd, .br_imm, .br_i_type, .br_lui,
        .rdat1, .rdat2, .rsel1, .rsel2, .fu_en,
        .iss_op, .iss_rd, .iss_imm, .iss_rdat1, .iss_rdat2
    );

endmodule

`default_nettype wire

// File: design/regfile.sv
/* register file */

`timescale 1ns/1ps
`default_nettype none

module regfile
    import isa_pkg::*;
#(
    parameter int DATA_WIDTH = isa_pkg::DATA_WIDTH
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  wen,
    input  regbits_t              wsel,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  regbits_t              rsel1,
    input  regbits_t              rsel2,
    output logic [DATA_WIDTH-1:0] rdat1,
    output logic [DATA_WIDTH-1:0] rdat2
);

    logic [DATA_WIDTH-1:0] regs [REG_COUNT];

    // x0 is hardwired, a write in the same cycle bypasses to the read
    function automatic logic [DATA_WIDTH-1:0] read_port(regbits_t sel);
        if (sel == '0)
            return '0;
        if (wen && wsel == sel)
            return wdata;
        return regs[sel];
    endfunction

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= '0;
        end else if (wen && wsel != '0) begin
            regs[wsel] <= wdata;
        end
    end

    always_comb begin
        rdat1 = read_port(rsel1);
        rdat2 = read_port(rsel2);
    end

endmodule

`default_nettype wire

// File: verif/issue_checker.sv
/* issue stage checker */

`timescale 1ns/1ps
`default_nettype none

module issue_checker
    import isa_pkg::*;
    import issue_pkg::*;
(
    input  logic              CLK,
    input  logic              nRST,
    input  logic [NUM_FU-1:0] busy,
    input  logic [NUM_FU-1:0] fu_en,
    input  aluop_e            iss_op,
    input  regbits_t          iss_rd,
    input  word_t             iss_imm,
    input  word_t             iss_rdat1,
    input  word_t             iss_rdat2,
    input  logic              arm,
    input  logic              must_issue,
    input  logic              hold,
    input  logic              idle_chk,
    input  logic              test_end,
    input  logic              all_done,
    input  int                test_num,
    input  fu_e               exp_unit,
    input  aluop_e            exp_op,
    input  regbits_t          exp_rd,
    input  word_t             exp_imm,
    input  word_t             exp_r1,
    input  word_t             exp_r2,
    output int                errors
);

    // previous negedge sample, for edge detection and hold compare
    logic [NUM_FU-1:0] en_q;
    logic [NUM_FU-1:0] busy_q;
    word_t             r1_q;
    word_t             r2_q;
    int                checks;
    int                tests;
    int                test_errs;

    initial begin
        errors    = 0;
        checks    = 0;
        tests     = 0;
        test_errs = 0;
        en_q      = '0;
    end

    task automatic check_value(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic report_failure(string msg);
        $display("%0t: %s", $time, msg);
        errors++;
        test_errs++;
    endtask

    // outputs are registered, so mid-cycle they are settled
    always @(negedge CLK) begin : sample
        logic [NUM_FU-1:0] rise;
        rise = fu_en & ~en_q;
        if (!nRST)
            rise = '0;
        if (rise != '0) begin
            if (!arm || rise != (3'b001 << exp_unit)) begin
                report_failure($sformatf("unexpected issue, fu_en rose to %b", fu_en));
            end else begin
                check_value("iss_op", word_t'(iss_op), word_t'(exp_op));
                check_value("iss_rd", word_t'(iss_rd), word_t'(exp_rd));
                check_value("iss_imm", iss_imm, exp_imm);
                check_value("iss_rdat1", iss_rdat1, exp_r1);
                check_value("iss_rdat2", iss_rdat2, exp_r2);
            end
        end else if (must_issue) begin
            report_failure($sformatf("fu_en[%0d] did not rise on the expected edge", exp_unit));
        end
        // frozen stage keeps packet and busy
        if (hold) begin
            check_value("held busy", word_t'(busy), word_t'(busy_q));
            check_value("held iss_rdat1", iss_rdat1, r1_q);
            check_value("held iss_rdat2", iss_rdat2, r2_q);
        end
        if (idle_chk) begin
            check_value("busy", word_t'(busy), '0);
            check_value("fu_en", word_t'(fu_en), '0);
        end
        if (test_end) begin
            tests++;
            if (test_errs == 0)
                $display("test %0d passed", test_num);
            else
                $display("test %0d failed with %0d errors", test_num, test_errs);
            test_errs = 0;
        end
        if (all_done)
            $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        en_q   = fu_en;
        busy_q = busy;
        r1_q   = iss_rdat1;
        r2_q   = iss_rdat2;
    end

endmodule

`default_nettype wire

// File: verif/issue_tb.sv
/* issue stage testbench */

`timescale 1ns/1ps
`default_nettype none

module issue_tb
    import isa_pkg::*;
    import issue_pkg::*;
();

    localparam int PERIOD     = 4;
    localparam int RST_CYCLES = 8;
    localparam int NUM_TESTS  = 11;
    localparam int LIMIT      = RST_CYCLES + 40 * NUM_TESTS;

    typedef enum int {T_RESET, T_PLAIN, T_DEP, T_OLDEST, T_FREEZE} kind_e;

    typedef struct {
        kind_e    kind;
        fu_e      fu;
        aluop_e   op;
        regbits_t rs1;
        regbits_t rs2;
        regbits_t rd;
        logic     it;
        logic     lui;
    } entry_t;

    logic              CLK;
    logic              nRST;
    logic              disp_en;
    fu_e               disp_fu;
    aluop_e            disp_op;
    regbits_t          disp_rs1;
    regbits_t          disp_rs2;
    regbits_t          disp_rd;
    word_t             disp_imm;
    logic              disp_i_type;
    logic              disp_lui;
    tag_t              disp_t1;
    tag_t              disp_t2;
    logic              freeze;
    logic [NUM_FU-1:0] fu_done;
    logic              wb_en;
    regbits_t          wb_sel;
    word_t             wb_data;
    logic [NUM_FU-1:0] busy;
    logic [NUM_FU-1:0] fu_en;
    aluop_e            iss_op;
    regbits_t          iss_rd;
    word_t             iss_imm;
    word_t             iss_rdat1;
    word_t             iss_rdat2;

    // checker control and expected packet
    logic   arm;
    logic   must_issue;
    logic   hold;
    logic   idle_chk;
    logic   test_end;
    logic   all_done;
    int     test_num;
    fu_e    exp_unit;
    aluop_e exp_op;
    regbits_t exp_rd;
    word_t  exp_imm;
    word_t  exp_r1;
    word_t  exp_r2;
    int     errors;

    entry_t      tbl [NUM_TESTS];
    word_t       model [REG_COUNT];
    logic [31:0] lcg_state;
    int          cycles;

    issue_top u_issue_top (
        .CLK, .nRST, .disp_en, .disp_fu, .disp_op, .disp_rs1, .disp_rs2, .disp_rd,
        .disp_imm, .disp_i_type, .disp_lui, .disp_t1, .disp_t2, .freeze, .fu_done,
        .wb_en, .wb_sel, .wb_data, .busy, .fu_en, .iss_op, .iss_rd, .iss_imm,
        .iss_rdat1, .iss_rdat2
    );

    issue_checker u_checker (
        .CLK, .nRST, .busy, .fu_en, .iss_op, .iss_rd, .iss_imm, .iss_rdat1, .iss_rdat2,
        .arm, .must_issue, .hold, .idle_chk, .test_end, .all_done, .test_num,
        .exp_unit, .exp_op, .exp_rd, .exp_imm, .exp_r1, .exp_r2, .errors
    );

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // run limit
    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run went past %0d cycles", LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic entry_t make_entry(kind_e kind, fu_e fu, aluop_e op, regbits_t rs1,
                                          regbits_t rs2, regbits_t rd, logic it, logic lui);
        entry_t e;
        e.kind = kind;
        e.fu   = fu;
        e.op   = op;
        e.rs1  = rs1;
        e.rs2  = rs2;
        e.rd   = rd;
        e.it   = it;
        e.lui  = lui;
        return e;
    endfunction

    // inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge CLK);
        #1;
    endtask

    // operand rule: lui zeroes op1, alu i-type takes the immediate as op2
    task automatic set_expect(fu_e fu, aluop_e op, regbits_t rs1, regbits_t rs2, regbits_t rd,
                              logic it, logic lui, word_t imm);
        exp_unit = fu;
        exp_op   = op;
        exp_rd   = rd;
        exp_imm  = imm;
        exp_r1   = lui ? '0 : model[rs1];
        exp_r2   = (it && fu == FU_ALU) ? imm : model[rs2];
    endtask

    task automatic dispatch(fu_e fu, aluop_e op, regbits_t rs1, regbits_t rs2, regbits_t rd,
                            logic it, logic lui, word_t imm, tag_t t1);
        disp_en     = 1'b1;
        disp_fu     = fu;
        disp_op     = op;
        disp_rs1    = rs1;
        disp_rs2    = rs2;
        disp_rd     = rd;
        disp_imm    = imm;
        disp_i_type = it;
        disp_lui    = lui;
        disp_t1     = t1;
        disp_t2     = '0;
    endtask

    task automatic write_reg(regbits_t sel, word_t data);
        wb_en   = 1'b1;
        wb_sel  = sel;
        wb_data = data;
        if (sel != '0)
            model[sel] = data;
    endtask

    // wait past the checker sample of the issuing edge
    task automatic wait_issue(fu_e fu);
        while (!fu_en[fu])
            step();
        #2;
    endtask

    task automatic complete(logic [NUM_FU-1:0] mask);
        step();
        fu_done = mask;
        step();
        fu_done  = '0;
        idle_chk = 1'b1;
        #2;
        idle_chk = 1'b0;
    endtask

    task automatic run_reset();
        idle_chk = 1'b1;
        #2;
        idle_chk = 1'b0;
        // preload x1..x31
        for (int r = 1; r < REG_COUNT; r++) begin
            step();
            write_reg(regbits_t'(r), next_rand());
        end
        step();
        wb_en = 1'b0;
    endtask

    // issue lands exactly one edge after acceptance
    task automatic run_plain(entry_t e);
        word_t imm;
        imm = next_rand();
        step();
        set_expect(e.fu, e.op, e.rs1, e.rs2, e.rd, e.it, e.lui, imm);
        arm = 1'b1;
        dispatch(e.fu, e.op, e.rs1, e.rs2, e.rd, e.it, e.lui, imm, 2'd0);
        step();
        disp_en = 1'b0;
        step();
        must_issue = 1'b1;
        #2;
        must_issue = 1'b0;
        arm        = 1'b0;
        complete(3'b001 << e.fu);
    endtask

    task automatic run_dep(entry_t e);
        word_t imm;
        word_t wdata;
        imm   = next_rand();
        wdata = next_rand();
        // producer on load/store stays in execute
        step();
        set_expect(FU_LDST, e.op, e.rs2, e.rs1, e.rd, 1'b0, 1'b0, imm);
        arm = 1'b1;
        dispatch(FU_LDST, e.op, e.rs2, e.rs1, e.rd, 1'b0, 1'b0, imm, 2'd0);
        step();
        disp_en = 1'b0;
        wait_issue(FU_LDST);
        arm = 1'b0;
        // consumer tagged on load/store, any issue now is an error
        step();
        dispatch(FU_ALU, e.op, e.rs1, e.rs2, e.rd, e.it, e.lui, imm, 2'd2);
        step();
        disp_en = 1'b0;
        repeat (4) step();
        write_reg(e.rs1, wdata);
        set_expect(FU_ALU, e.op, e.rs1, e.rs2, e.rd, e.it, e.lui, imm);
        arm     = 1'b1;
        fu_done = 3'b010;
        step();
        fu_done = '0;
        wb_en   = 1'b0;
        wait_issue(FU_ALU);
        arm = 1'b0;
        complete(3'b001);
    endtask

    task automatic run_oldest(entry_t e);
        word_t imm;
        imm = next_rand();
        step();
        set_expect(FU_BRANCH, e.op, e.rs1, e.rs2, e.rd, 1'b0, 1'b0, imm);
        arm = 1'b1;
        dispatch(FU_BRANCH, e.op, e.rs1, e.rs2, e.rd, 1'b0, 1'b0, imm, 2'd0);
        step();
        disp_en = 1'b0;
        wait_issue(FU_BRANCH);
        arm = 1'b0;
        // load/store first, so age has to beat the lower alu index
        step();
        dispatch(FU_LDST, e.op, e.rs2, e.rs1, e.rd, 1'b0, 1'b0, imm, 2'd3);
        step();
        dispatch(FU_ALU, e.op, e.rs1, e.rs2, e.rd, 1'b0, 1'b0, imm, 2'd3);
        step();
        disp_en = 1'b0;
        set_expect(FU_LDST, e.op, e.rs2, e.rs1, e.rd, 1'b0, 1'b0, imm);
        arm     = 1'b1;
        fu_done = 3'b100;
        step();
        fu_done = '0;
        wait_issue(FU_LDST);
        set_expect(FU_ALU, e.op, e.rs1, e.rs2, e.rd, 1'b0, 1'b0, imm);
        step();
        must_issue = 1'b1;
        #2;
        must_issue = 1'b0;
        arm        = 1'b0;
        complete(3'b011);
    endtask

    task automatic run_freeze(entry_t e);
        word_t imm;
        imm = next_rand();
        step();
        set_expect(e.fu, e.op, e.rs1, e.rs2, e.rd, e.it, e.lui, imm);
        dispatch(e.fu, e.op, e.rs1, e.rs2, e.rd, e.it, e.lui, imm, 2'd0);
        step();
        freeze = 1'b1;
        // dispatch to the empty load/store row must be dropped while frozen
        dispatch(FU_LDST, e.op, e.rs2, e.rs1, e.rd, 1'b0, 1'b0, imm, 2'd0);
        step();
        hold = 1'b1;
        repeat (4) step();
        hold    = 1'b0;
        freeze  = 1'b0;
        disp_en = 1'b0;
        arm     = 1'b1;
        step();
        must_issue = 1'b1;
        #2;
        must_issue = 1'b0;
        arm        = 1'b0;
        complete(3'b001 << e.fu);
    endtask

    initial begin
        nRST = 1'b0;
        cycles = 0;
        lcg_state = 32'd83155;
        disp_en = 1'b0;
        dispatch(FU_ALU, ALU_ADD, '0, '0, '0, 1'b0, 1'b0, '0, 2'd0);
        disp_en = 1'b0;
        freeze = 1'b0;
        fu_done = '0;
        wb_en = 1'b0;
        wb_sel = '0;
        wb_data = '0;
        arm = 1'b0;
        must_issue = 1'b0;
        hold = 1'b0;
        idle_chk = 1'b0;
        test_end = 1'b0;
        all_done = 1'b0;
        test_num = 0;
        set_expect(FU_ALU, ALU_ADD, '0, '0, '0, 1'b0, 1'b0, '0);
        for (int r = 0; r < REG_COUNT; r++)
            model[r] = '0;

        tbl[0]  = make_entry(T_RESET, FU_ALU, ALU_ADD, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0);
        tbl[1]  = make_entry(T_PLAIN, FU_ALU, ALU_ADD, 5'd3, 5'd5, 5'd7, 1'b0, 1'b0);
        tbl[2]  = make_entry(T_PLAIN, FU_LDST, ALU_ADD, 5'd1, 5'd2, 5'd4, 1'b0, 1'b0);
        tbl[3]  = make_entry(T_PLAIN, FU_BRANCH, ALU_SUB, 5'd10, 5'd11, 5'd0, 1'b0, 1'b0);
        tbl[4]  = make_entry(T_PLAIN, FU_ALU, ALU_XOR, 5'd6, 5'd8, 5'd9, 1'b1, 1'b0);
        tbl[5]  = make_entry(T_PLAIN, FU_ALU, ALU_ADD, 5'd12, 5'd13, 5'd14, 1'b1, 1'b1);
        // i-type flag on load/store keeps the register operand
        tbl[6]  = make_entry(T_PLAIN, FU_LDST, ALU_ADD, 5'd15, 5'd16, 5'd17, 1'b1, 1'b0);
        tbl[7]  = make_entry(T_PLAIN, FU_ALU, ALU_OR, 5'd0, 5'd20, 5'd21, 1'b0, 1'b0);
        tbl[8]  = make_entry(T_DEP, FU_ALU, ALU_SLT, 5'd9, 5'd22, 5'd23, 1'b0, 1'b0);
        tbl[9]  = make_entry(T_OLDEST, FU_ALU, ALU_AND, 5'd24, 5'd25, 5'd26, 1'b0, 1'b0);
        tbl[10] = make_entry(T_FREEZE, FU_ALU, ALU_SLL, 5'd27, 5'd28, 5'd29, 1'b0, 1'b0);

        repeat (RST_CYCLES) @(posedge CLK);
        #1;
        nRST = 1'b1;

        for (int i = 0; i < NUM_TESTS; i++) begin
            test_num = i;
            case (tbl[i].kind)
                T_RESET:  run_reset();
                T_PLAIN:  run_plain(tbl[i]);
                T_DEP:    run_dep(tbl[i]);
                T_OLDEST: run_oldest(tbl[i]);
                default:  run_freeze(tbl[i]);
            endcase
            step();
            test_end = 1'b1;
            #2;
            test_end = 1'b0;
        end

        step();
        all_done = 1'b1;
        #2;
        all_done = 1'b0;
        #1;
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
design/isa_pkg.sv
design/issue_pkg.sv
design/fust_slot.sv
design/issue_select.sv
design/regfile.sv
design/issue_latch.sv
design/issue_top.sv
verif/issue_checker.sv
verif/issue_tb.sv
